/* hdl/rmii_rx_defs.svh */
/* RMII receive path parameters
   field widths, APB register map and frame check constants */
`ifndef RMII_RX_DEFS_SVH
`define RMII_RX_DEFS_SVH

// frame length field, bytes incl. FCS
`define RX_LEN_W        11
`define RX_MIN_LEN      64

// reflected CRC-32 register after a good frame, FCS included
`define RX_CRC_RESIDUE  32'hDEBB20E3

`define RX_CNT_W        16     // event counter width

// APB byte offsets
`define RX_REG_MAC_LO   8'h00
`define RX_REG_MAC_HI   8'h04
`define RX_REG_CTRL     8'h08  // bit 0 promiscuous
`define RX_REG_GOOD     8'h10
`define RX_REG_CRCERR   8'h14
`define RX_REG_FILT     8'h18
`define RX_REG_OVF      8'h1C

`endif

/* hdl/rmii_rx_pkg.sv */
/* RMII receive path types
   byte stream beat, per-frame status word and deframer states */
`include "rmii_rx_defs.svh"

package rmii_rx_pkg;

	// one beat of the received byte stream
	typedef struct packed {
		logic [7:0] data;
		logic       valid;  // data byte present
		logic       sof;    // first byte after the SFD
		logic       eof;    // end of frame, never with valid
	} rx_beat_t;

	// verdict for one finished frame
	typedef struct packed {
		logic [`RX_LEN_W-1:0] length;  // bytes incl. FCS
		logic                 crc_ok;
		logic                 addr_match;
		logic                 runt;
		logic                 accepted;
	} rx_status_t;

	// deframer FSM
	typedef enum logic [1:0] {
		st_idle,
		st_preamble,  // hunting for the SFD
		st_body,
		st_done       // wait for data valid to drop
	} rx_state_e;

endpackage

/* hdl/rmii_rx_deframer.sv */
/* RMII receive deframer
   samples the PHY pins, hunts the SFD and packs dibits into byte beats */
`timescale 1ns/1ps

module rmii_rx_deframer (
	input  logic                  REF_CLK,
	input  logic                  arst_n,
	input  logic                  crs_dv,
	input  logic                  rxd0,
	input  logic                  rxd1,
	input  logic                  rx_afull,
	output rmii_rx_pkg::rx_beat_t beat,
	output logic                  drop
);
	import rmii_rx_pkg::*;

	localparam logic [7:0] sfd_byte = 8'hD5;

	logic       crs_q;
	logic       crs_qq;
	logic [1:0] rxd_q;   // {rxd1, rxd0}
	logic [7:0] win;     // last four dibits, oldest at the bottom
	logic [7:0] nxt;
	logic       dv;
	logic [1:0] cnt;     // dibit position within the byte
	logic       first;
	rx_state_e  state;

	// crs_dv toggles at the frame tail, so OR it with its delayed copy
	assign dv  = crs_q | crs_qq;
	assign nxt = {rxd_q, win[7:2]};  // window incl. the dibit now in rxd_q

	always_ff @(posedge REF_CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			crs_q  <= 1'b0;
			crs_qq <= 1'b0;
			rxd_q  <= 2'b00;
			win    <= 8'h00;
		end
		else
		begin
			crs_q  <= crs_dv;
			crs_qq <= crs_q;
			rxd_q  <= {rxd1, rxd0};
			win    <= nxt;  // LSB first, new dibit enters at the top
		end
	end

	always_ff @(posedge REF_CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= st_idle;
			cnt   <= 2'd0;
			first <= 1'b0;
			drop  <= 1'b0;
			beat  <= '0;
		end
		else
		begin
			beat.valid <= 1'b0;
			beat.sof   <= 1'b0;
			beat.eof   <= 1'b0;
			drop       <= 1'b0;
			case (state)
				st_idle:
				begin
					if (crs_q)
					begin
						if (rx_afull)  // no room, skip the whole frame
						begin
							drop  <= 1'b1;
							state <= st_done;
						end
						else
							state <= st_preamble;
					end
				end
				st_preamble:
				begin
					if (!dv)
						state <= st_idle;  // carrier lost before SFD
					else if (nxt == sfd_byte)
					begin
						state <= st_body;
						cnt   <= 2'd0;
						first <= 1'b1;
					end
				end
				st_body:
				begin
					if (!dv)
					begin
						beat.eof <= 1'b1;  // partial byte, if any, is discarded
						state    <= st_done;
					end
					else
					begin
						cnt <= cnt + 2'd1;
						if (cnt == 2'd3)
						begin
							beat.data  <= nxt;
							beat.valid <= 1'b1;
							beat.sof   <= first;
							first      <= 1'b0;
						end
					end
				end
				st_done:
					if (!dv)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

/* hdl/rx_fcs_checker.sv */
/* frame check sequence checker
   running reflected CRC-32 over the frame bytes, residue compare at end of frame */
`timescale 1ns/1ps
`include "rmii_rx_defs.svh"

module rx_fcs_checker (
	input  logic                  REF_CLK,
	input  logic                  arst_n,
	input  rmii_rx_pkg::rx_beat_t beat,
	output logic                  crc_ok
);
	import rmii_rx_pkg::*;

	localparam logic [31:0] crc_poly = 32'hEDB88320;  // 04C11DB7 reflected

	logic [31:0] crc;
	logic [31:0] crc_seed;

	// one byte through the CRC, LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h000000, d};
		for (int i = 0; i < 8; i++)
			r = r[0] ? ((r >> 1) ^ crc_poly) : (r >> 1);
		return r;
	endfunction

	assign crc_seed = beat.sof ? 32'hFFFFFFFF : crc;  // restart on every frame

	always_ff @(posedge REF_CLK)
	begin
		if (beat.valid)
			crc <= crc_byte(crc_seed, beat.data);
	end

	always_ff @(posedge REF_CLK or negedge arst_n)
	begin
		if (!arst_n)
			crc_ok <= 1'b0;
		else if (beat.eof)
			crc_ok <= (crc == `RX_CRC_RESIDUE);  // FCS bytes already folded in
	end

endmodule

/* hdl/rx_addr_filter.sv */
/* destination address filter
   matches the first six frame bytes against the station address or broadcast */
`timescale 1ns/1ps

module rx_addr_filter (
	input  logic                  REF_CLK,
	input  logic                  arst_n,
	input  rmii_rx_pkg::rx_beat_t beat,
	input  logic [47:0]           station_mac,
	output logic                  addr_match
);
	import rmii_rx_pkg::*;

	logic [2:0]  idx;     // destination bytes seen so far
	logic        uni;
	logic        bc;
	logic [39:0] mac_sr;  // remaining address bytes, next one at the bottom

	always_ff @(posedge REF_CLK)
	begin
		if (beat.valid && beat.sof)
			mac_sr <= station_mac[47:8];  // low byte goes out first on the wire
		else if (beat.valid)
			mac_sr <= mac_sr >> 8;
	end

	always_ff @(posedge REF_CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			idx        <= 3'd0;
			uni        <= 1'b0;
			bc         <= 1'b0;
			addr_match <= 1'b0;
		end
		else
		begin
			if (beat.valid && beat.sof)
			begin
				idx <= 3'd1;
				uni <= (beat.data == station_mac[7:0]);
				bc  <= (beat.data == 8'hFF);
			end
			else if (beat.valid && idx < 3'd6)
			begin
				idx <= idx + 3'd1;
				uni <= uni && (beat.data == mac_sr[7:0]);
				bc  <= bc && (beat.data == 8'hFF);
			end

			// a frame shorter than the address never matches
			if (beat.eof)
				addr_match <= (idx == 3'd6) && (uni || bc);
		end
	end

endmodule

/* hdl/rx_frame_status.sv */
/* frame status combiner
   merges the checker verdicts and the length into a status word, keeps event counters */
`timescale 1ns/1ps
`include "rmii_rx_defs.svh"

module rx_frame_status (
	input  logic                             REF_CLK,
	input  logic                             arst_n,
	input  rmii_rx_pkg::rx_beat_t            beat,
	input  logic                             crc_ok,
	input  logic                             addr_match,
	input  logic                             promisc,
	input  logic                             drop,
	output rmii_rx_pkg::rx_status_t          frame_status,
	output logic                             status_valid,
	output logic [3:0][`RX_CNT_W-1:0]        counters  // good, crc_err, filt, ovf
);
	import rmii_rx_pkg::*;

	logic [`RX_LEN_W-1:0] len;
	logic                 eof_d;  // checker verdicts valid now
	logic                 runt;
	rx_status_t           status_d;

	assign runt = (len < `RX_LEN_W'(`RX_MIN_LEN));

	always_comb
	begin
		status_d.length     = len;
		status_d.crc_ok     = crc_ok;
		status_d.addr_match = addr_match;
		status_d.runt       = runt;
		status_d.accepted   = crc_ok && !runt && (addr_match || promisc);
	end

	always_ff @(posedge REF_CLK)
	begin
		if (eof_d)
			frame_status <= status_d;
	end

	always_ff @(posedge REF_CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			len          <= '0;
			eof_d        <= 1'b0;
			status_valid <= 1'b0;
			counters     <= '0;
		end
		else
		begin
			eof_d        <= beat.eof;
			status_valid <= eof_d;

			if (beat.valid && beat.sof)
				len <= `RX_LEN_W'(1);
			else if (beat.valid && len != '1)  // saturate on giant frames
				len <= len + 1'b1;

			// exactly one of the frame counters per finished frame
			if (eof_d)
			begin
				if (status_d.accepted)
					counters[0] <= counters[0] + 1'b1;
				else if (!crc_ok)
					counters[1] <= counters[1] + 1'b1;
				else
					counters[2] <= counters[2] + 1'b1;
			end

			if (drop)
				counters[3] <= counters[3] + 1'b1;
		end
	end

endmodule

/* hdl/rx_apb_regs.sv */
/* APB configuration slave
   station address, promiscuous control bit and event counter readout */
`timescale 1ns/1ps
`include "rmii_rx_defs.svh"

module rx_apb_regs (
	input  logic                      REF_CLK,
	input  logic                      arst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [7:0]                paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic [3:0][`RX_CNT_W-1:0] counters,
	output logic [47:0]               station_mac,
	output logic                      promisc
);
	logic        setup;
	logic        access;
	logic        is_cfg;
	logic        is_cnt;
	logic        bad;
	logic [31:0] rdata;

	assign setup  = psel && !penable;
	assign access = psel && penable;
	assign pready = 1'b1;  // zero wait states

	always_comb
	begin
		is_cfg = 1'b0;
		is_cnt = 1'b0;
		rdata  = 32'h0;
		case (paddr)
			`RX_REG_MAC_LO:
			begin
				is_cfg = 1'b1;
				rdata  = station_mac[31:0];
			end
			`RX_REG_MAC_HI:
			begin
				is_cfg = 1'b1;
				rdata  = {16'h0000, station_mac[47:32]};
			end
			`RX_REG_CTRL:
			begin
				is_cfg = 1'b1;
				rdata  = {31'h0, promisc};
			end
			`RX_REG_GOOD, `RX_REG_CRCERR, `RX_REG_FILT, `RX_REG_OVF:
			begin
				is_cnt = 1'b1;
				rdata  = {{(32-`RX_CNT_W){1'b0}}, counters[paddr[3:2]]};  // 10..1C map to 0..3
			end
			default:
				rdata = 32'h0;
		endcase
	end

	assign bad = !(is_cfg || is_cnt) || (pwrite && is_cnt);  // counters are read only

	// read data and error are set up one cycle early, shown in the access cycle
	always_ff @(posedge REF_CLK)
	begin
		if (setup)
			prdata <= rdata;
	end

	always_ff @(posedge REF_CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pslverr     <= 1'b0;
			station_mac <= 48'h0;
			promisc     <= 1'b0;
		end
		else
		begin
			pslverr <= setup && bad;
			if (access && pwrite)
			begin
				case (paddr)
					`RX_REG_MAC_LO: station_mac[31:0]  <= pwdata;
					`RX_REG_MAC_HI: station_mac[47:32] <= pwdata[15:0];
					`RX_REG_CTRL:   promisc            <= pwdata[0];
					default:        promisc            <= promisc;
				endcase
			end
		end
	end

endmodule

/* hdl/rmii_rx_subsys.sv */
/* RMII receive subsystem
   deframer, FCS and address checkers, status combiner and APB registers */
`timescale 1ns/1ps
`include "rmii_rx_defs.svh"

module rmii_rx_subsys (
	input  logic                    REF_CLK,
	input  logic                    arst_n,
	input  logic                    crs_dv,
	input  logic                    rxd0,
	input  logic                    rxd1,
	input  logic                    rx_afull,
	output rmii_rx_pkg::rx_beat_t   rx_beat,
	output rmii_rx_pkg::rx_status_t frame_status,
	output logic                    status_valid,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [7:0]              paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr
);
	import rmii_rx_pkg::*;

	logic                      drop;
	logic                      crc_ok;
	logic                      addr_match;
	logic [3:0][`RX_CNT_W-1:0] counters;
	logic [47:0]               station_mac;
	logic                      promisc;

	rmii_rx_deframer rmii_rx_deframer_inst (
		.REF_CLK  (REF_CLK),
		.arst_n   (arst_n),
		.crs_dv   (crs_dv),
		.rxd0     (rxd0),
		.rxd1     (rxd1),
		.rx_afull (rx_afull),
		.beat     (rx_beat),
		.drop     (drop)
	);

	rx_fcs_checker rx_fcs_checker_inst (
		.REF_CLK (REF_CLK),
		.arst_n  (arst_n),
		.beat    (rx_beat),
		.crc_ok  (crc_ok)
	);

	rx_addr_filter rx_addr_filter_inst (
		.REF_CLK     (REF_CLK),
		.arst_n      (arst_n),
		.beat        (rx_beat),
		.station_mac (station_mac),
		.addr_match  (addr_match)
	);

	rx_frame_status rx_frame_status_inst (
		.REF_CLK      (REF_CLK),
		.arst_n       (arst_n),
		.beat         (rx_beat),
		.crc_ok       (crc_ok),
		.addr_match   (addr_match),
		.promisc      (promisc),
		.drop         (drop),
		.frame_status (frame_status),
		.status_valid (status_valid),
		.counters     (counters)
	);

	rx_apb_regs rx_apb_regs_inst (
		.REF_CLK     (REF_CLK),
		.arst_n      (arst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.counters    (counters),
		.station_mac (station_mac),
		.promisc     (promisc)
	);

endmodule

/* bench/rmii_rx_assert.sv */
/* RMII receive subsystem assertions
   byte stream framing, status timing and APB ready */
`timescale 1ns/1ps

module rmii_rx_assert (
	input logic                  REF_CLK,
	input logic                  arst_n,
	input rmii_rx_pkg::rx_beat_t rx_beat,
	input logic                  status_valid,
	input logic                  pready
);
	import rmii_rx_pkg::*;

	valid_eof_apart: assert property (@(posedge REF_CLK) disable iff (!arst_n)
		!(rx_beat.valid && rx_beat.eof))
		else $error("rx_beat valid and eof high together");

	// status two cycles after eof, both ways
	status_after_eof: assert property (@(posedge REF_CLK) disable iff (!arst_n)
		rx_beat.eof |-> ##2 status_valid)
		else $error("status_valid missing two cycles after eof");

	status_from_eof: assert property (@(posedge REF_CLK) disable iff (!arst_n)
		status_valid |-> $past(rx_beat.eof, 2))
		else $error("status_valid without eof two cycles earlier");

	pready_high: assert property (@(posedge REF_CLK) disable iff (!arst_n) pready)
		else $error("pready went low");

endmodule

bind rmii_rx_subsys rmii_rx_assert rmii_rx_assert_inst (
	.REF_CLK      (REF_CLK),
	.arst_n       (arst_n),
	.rx_beat      (rx_beat),
	.status_valid (status_valid),
	.pready       (pready)
);

/* bench/rmii_rx_tb.sv */
/* RMII receive subsystem testbench
   random frames checked against a reference model, plus APB config and counters */
`timescale 1ns/1ps
`include "rmii_rx_defs.svh"

module rmii_rx_tb;
	import rmii_rx_pkg::*;

	localparam int          n_frames  = 40;  // second half runs promiscuous
	localparam int          wd_cycles = n_frames * 140 * 4 + 2000;
	localparam logic [47:0] station   = 48'h0A1B_2C3D_4E02;

	logic        REF_CLK;
	logic        arst_n;
	logic        crs_dv;
	logic        rxd0;
	logic        rxd1;
	logic        rx_afull;
	rx_beat_t    rx_beat;
	rx_status_t  frame_status;
	logic        status_valid;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] rng;
	logic        promisc_on;
	rx_beat_t    exp_beats[$];
	rx_status_t  exp_stats[$];
	int          good_cnt;
	int          crcerr_cnt;
	int          filt_cnt;
	int          ovf_cnt;

	rmii_rx_subsys rmii_rx_subsys_inst (
		.REF_CLK      (REF_CLK),
		.arst_n       (arst_n),
		.crs_dv       (crs_dv),
		.rxd0         (rxd0),
		.rxd1         (rxd1),
		.rx_afull     (rx_afull),
		.rx_beat      (rx_beat),
		.frame_status (frame_status),
		.status_valid (status_valid),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	initial
	begin
		REF_CLK = 1'b0;
		forever
			#10 REF_CLK = ~REF_CLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// bit serial CRC-32 reference
	function automatic logic [31:0] crc32_serial(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int b = 0; b < 8; b++)
		begin
			fb = r[0] ^ d[b];
			r  = {1'b0, r[31:1]} ^ (fb ? 32'hEDB88320 : 32'h0);
		end
		return r;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_beat(input rx_beat_t got, input rx_beat_t exp);
		if (got !== exp)
			report_failure($sformatf("error: rx_beat got %h expected %h", got, exp));
	endtask

	task automatic verify_status(input rx_status_t got, input rx_status_t exp);
		if (got !== exp)
			report_failure($sformatf("error: frame_status got %h expected %h", got, exp));
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge REF_CLK);
		psel    <= 1'b1;  // setup cycle
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge REF_CLK);
		penable <= 1'b1;
		@(negedge REF_CLK);
		while (!pready)
		begin
			waited++;
			if (waited > 16)
				report_failure("APB transfer never saw pready");
			@(negedge REF_CLK);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge REF_CLK);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	// one byte as four dibits LSB first
	task automatic send_byte(input logic [7:0] b, input logic af);
		for (int i = 0; i < 4; i++)
		begin
			@(posedge REF_CLK);
			crs_dv   <= 1'b1;
			rxd0     <= b[2*i];
			rxd1     <= b[2*i+1];
			rx_afull <= af;
		end
	endtask

	task automatic send_frame(input int len, input int dst_sel, input logic corrupt,
		input logic afull);
		logic [7:0]  bytes[$];
		logic [7:0]  b;
		logic [31:0] crc;
		logic [31:0] fcs;
		rx_beat_t    bt;
		rx_status_t  st;
		crc = 32'hFFFFFFFF;
		for (int i = 0; i < len - 4; i++)
		begin
			rng = xorshift32(rng);
			b   = rng[7:0];
			if (i < 6 && dst_sel == 0)
				b = station[8*i +: 8];
			else if (i < 6 && dst_sel == 1)
				b = 8'hFF;
			else if (i == 0)
				b = 8'h12;  // neither station nor broadcast
			crc = crc32_serial(crc, b);
			bytes.push_back(b);
		end
		fcs = ~crc;
		if (corrupt)
			fcs = fcs ^ 32'h0000_0100;
		for (int i = 0; i < 4; i++)
			bytes.push_back(fcs[8*i +: 8]);

		st.length     = `RX_LEN_W'(len);
		st.crc_ok     = !corrupt;
		st.addr_match = (dst_sel != 2);
		st.runt       = (len < `RX_MIN_LEN);
		st.accepted   = st.crc_ok && !st.runt && (st.addr_match || promisc_on);

		if (afull)
			ovf_cnt++;  // dropped whole
		else
		begin
			foreach (bytes[i])
			begin
				bt.data  = bytes[i];
				bt.valid = 1'b1;
				bt.sof   = (i == 0);
				bt.eof   = 1'b0;
				exp_beats.push_back(bt);
			end
			exp_stats.push_back(st);
			if (st.accepted)
				good_cnt++;
			else if (!st.crc_ok)
				crcerr_cnt++;
			else
				filt_cnt++;
		end

		repeat (7)
			send_byte(8'h55, afull);
		send_byte(8'hD5, afull);  // SFD
		foreach (bytes[i])
			send_byte(bytes[i], afull);
		repeat (12)
		begin
			@(posedge REF_CLK);
			crs_dv   <= 1'b0;
			rxd0     <= 1'b0;
			rxd1     <= 1'b0;
			rx_afull <= 1'b0;
		end
	endtask

	// output monitor on the falling edge
	initial
	begin
		int since_byte;
		since_byte = 0;
		forever
		begin
			@(negedge REF_CLK);
			since_byte++;
			if (arst_n && rx_beat.valid)
			begin
				since_byte = 0;
				if (exp_beats.size() == 0)
					report_failure("a byte came out while none was expected");
				else
					check_beat(rx_beat, exp_beats.pop_front());
			end
			if (arst_n && rx_beat.eof)
			begin
				if (exp_beats.size() != 0)
					report_failure("end of frame came before all frame bytes");
				else if (since_byte < 1 || since_byte > 4)
					report_failure("end of frame not one to four cycles after the last byte");
			end
			if (arst_n && status_valid)
			begin
				if (exp_stats.size() == 0)
					report_failure("a status word came out while none was expected");
				else if (exp_beats.size() != 0)
					report_failure("status word came before all frame bytes");
				else
					verify_status(frame_status, exp_stats.pop_front());
			end
		end
	end

	initial
	begin
		repeat (wd_cycles) @(posedge REF_CLK);
		report_failure("watchdog timeout, the run did not finish in time");
	end

	initial
	begin
		logic [31:0] rd;
		logic        err;
		int          len;
		int          dst_sel;
		logic        corrupt;
		logic        afull;
		int          waited;
		crs_dv     = 1'b0;
		rxd0       = 1'b0;
		rxd1       = 1'b0;
		rx_afull   = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = 8'h00;
		pwdata     = 32'h0;
		arst_n     = 1'b0;
		rng        = 32'd35;
		promisc_on = 1'b0;
		good_cnt   = 0;
		crcerr_cnt = 0;
		filt_cnt   = 0;
		ovf_cnt    = 0;
		repeat (8) @(posedge REF_CLK);
		arst_n <= 1'b1;
		repeat (2) @(posedge REF_CLK);

		apb_access(1'b1, `RX_REG_MAC_LO, station[31:0], rd, err);
		compare_word("pslverr", {31'h0, err}, 32'h0);
		apb_access(1'b1, `RX_REG_MAC_HI, {16'h0, station[47:32]}, rd, err);
		apb_access(1'b0, `RX_REG_MAC_LO, 32'h0, rd, err);
		compare_word("prdata MAC_LO", rd, station[31:0]);
		apb_access(1'b0, `RX_REG_MAC_HI, 32'h0, rd, err);
		compare_word("prdata MAC_HI", rd, {16'h0, station[47:32]});

		for (int f = 0; f < n_frames; f++)
		begin
			if (f == n_frames / 2)
			begin
				apb_access(1'b1, `RX_REG_CTRL, 32'h1, rd, err);
				promisc_on = 1'b1;
				apb_access(1'b0, `RX_REG_CTRL, 32'h0, rd, err);
				compare_word("prdata CTRL", rd, 32'h1);
			end
			rng     = xorshift32(rng);
			len     = 40 + int'(rng % 81);
			dst_sel = int'((rng >> 8) % 3);
			corrupt = ((rng >> 12) % 5 == 0);
			afull   = ((rng >> 16) % 8 == 0);
			if (f < 4)
			begin
				// good, bad FCS, foreign address, runt
				afull   = 1'b0;
				corrupt = (f == 1);
				dst_sel = (f == 2) ? 2 : 0;
				len     = (f == 3) ? 50 : 80;
			end
			else if (f == 4)
				afull = 1'b1;
			else if (f == n_frames / 2 || f == n_frames / 2 + 1)
			begin
				afull   = 1'b0;  // foreign then broadcast under promisc
				corrupt = 1'b0;
				len     = 80;
				dst_sel = (f == n_frames / 2) ? 2 : 1;
			end
			send_frame(len, dst_sel, corrupt, afull);
		end

		waited = 0;
		while (exp_stats.size() != 0)
		begin
			waited++;
			if (waited > 20)
				report_failure("status word of the last frame never came out");
			@(posedge REF_CLK);
		end

		apb_access(1'b0, `RX_REG_GOOD, 32'h0, rd, err);
		compare_word("prdata GOOD", rd, 32'(good_cnt));
		apb_access(1'b0, `RX_REG_CRCERR, 32'h0, rd, err);
		compare_word("prdata CRCERR", rd, 32'(crcerr_cnt));
		apb_access(1'b0, `RX_REG_FILT, 32'h0, rd, err);
		compare_word("prdata FILT", rd, 32'(filt_cnt));
		apb_access(1'b0, `RX_REG_OVF, 32'h0, rd, err);
		compare_word("prdata OVF", rd, 32'(ovf_cnt));

		apb_access(1'b1, `RX_REG_GOOD, 32'h1234, rd, err);  // counters are read only
		compare_word("pslverr", {31'h0, err}, 32'h1);
		apb_access(1'b0, 8'h20, 32'h0, rd, err);
		compare_word("pslverr", {31'h0, err}, 32'h1);
		apb_access(1'b0, `RX_REG_GOOD, 32'h0, rd, err);
		compare_word("prdata GOOD", rd, 32'(good_cnt));

		if (exp_beats.size() != 0 || exp_stats.size() != 0)
			report_failure("expected bytes or status words never came out");
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

/* compile.f */
+incdir+hdl
hdl/rmii_rx_pkg.sv
hdl/rmii_rx_deframer.sv
hdl/rx_fcs_checker.sv
hdl/rx_addr_filter.sv
hdl/rx_frame_status.sv
hdl/rx_apb_regs.sv
hdl/rmii_rx_subsys.sv
bench/rmii_rx_assert.sv
bench/rmii_rx_tb.sv

/* Bender.yml */
package:
  name: rmii_rx

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rmii_rx_pkg.sv
      - hdl/rmii_rx_deframer.sv
      - hdl/rx_fcs_checker.sv
      - hdl/rx_addr_filter.sv
      - hdl/rx_frame_status.sv
      - hdl/rx_apb_regs.sv
      - hdl/rmii_rx_subsys.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/rmii_rx_assert.sv
      - bench/rmii_rx_tb.sv
